//--- rtl/cache_pkg.sv
package cache_pkg;

   // cache geometry, the packed types below are sized from these
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int BYTE_OFF_W = 2;   // bytes in a word
   localparam int WORD_OFF_W = 2;   // 4 words per line
   localparam int INDEX_W    = 4;   // 16 lines
   localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;
   localparam int AXI_ID_W   = 4;

   typedef struct packed {
      logic [TAG_W-1:0]      tag;
      logic [INDEX_W-1:0]    index;
      logic [WORD_OFF_W-1:0] word_off;
      logic [BYTE_OFF_W-1:0] byte_off;
   } addr_fields_t;

   // same byte address, either flat or split into cache fields
   typedef union packed {
      logic [ADDR_W-1:0] word;
      addr_fields_t      f;
   } cache_addr_u;

   typedef struct packed {
      logic        valid;
      cache_addr_u addr;
   } cache_req_t;

   // one refill beat towards the line store
   typedef struct packed {
      logic                  we;
      logic [INDEX_W-1:0]    index;
      logic [WORD_OFF_W-1:0] word;
      logic [DATA_W-1:0]     data;
   } line_fill_t;

   typedef struct packed {
      logic [AXI_ID_W-1:0] id;
      logic [ADDR_W-1:0]   addr;
      logic [7:0]          len;
      logic [2:0]          size;
      logic [1:0]          burst;
      logic [3:0]          cache;
      logic [2:0]          prot;
   } axi_ar_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

endpackage

//--- rtl/cache_req_stage.sv
module cache_req_stage (
   input  logic                            clk_i,
   input  logic                            reset,
   input  logic                            wb_cyc_i,
   input  logic                            wb_stb_i,
   input  logic                            wb_we_i,
   input  logic [cache_pkg::ADDR_W-1:0]    wb_adr_i,
   output logic                            wb_ack_o,
   output logic                            wb_err_o,
   output logic [cache_pkg::DATA_W-1:0]    wb_dat_o,
   output cache_pkg::cache_req_t           req_o,
   input  logic                            lookup_done_i,
   input  logic [cache_pkg::DATA_W-1:0]    lookup_data_i
);

   logic                   busy_q;
   logic                   req_valid_q;
   cache_pkg::cache_addr_u req_addr_q;
   logic                   take;

   // new cycle only when idle and not in the answer cycle of the previous one,
   // the master may still hold stb with the old address there
   assign take = wb_cyc_i && wb_stb_i && !busy_q && !wb_ack_o && !wb_err_o;

   assign req_o.valid = req_valid_q;
   assign req_o.addr  = req_addr_q;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         busy_q      <= 1'b0;
         req_valid_q <= 1'b0;
         wb_ack_o    <= 1'b0;
         wb_err_o    <= 1'b0;
      end else begin
         req_valid_q <= take && !wb_we_i;   // single pulse to the tag stage
         wb_err_o    <= take && wb_we_i;    // writes are refused, no memory access
         wb_ack_o    <= lookup_done_i;
         if (take && !wb_we_i) begin
            busy_q <= 1'b1;
         end else if (lookup_done_i) begin
            busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         req_addr_q.word <= wb_adr_i;
      end
      if (lookup_done_i) begin
         wb_dat_o <= lookup_data_i;   // valid together with ack
      end
   end

   a_ack_err_excl : assert property (@(posedge clk_i) disable iff (reset)
      !(wb_ack_o && wb_err_o))
      else $error("ack and err raised together");

endmodule

//--- rtl/cache_tag_stage.sv
module cache_tag_stage (
   input  logic                                                 clk_i,
   input  logic                                                 reset,
   input  cache_pkg::cache_req_t                                req_i,
   output logic                                                 lookup_done_o,
   output logic [cache_pkg::DATA_W-1:0]                         dat_o,
   output logic                                                 refill_req_o,
   output logic [cache_pkg::TAG_W+cache_pkg::INDEX_W-1:0]       refill_addr_o,
   input  logic                                                 refill_done_i,
   output logic [cache_pkg::INDEX_W-1:0]                        store_rd_index_o,
   output logic [cache_pkg::WORD_OFF_W-1:0]                     store_rd_word_o,
   input  logic [cache_pkg::DATA_W-1:0]                         store_rd_data_i
);

   localparam int NLINES = 1 << cache_pkg::INDEX_W;

   logic [cache_pkg::TAG_W-1:0] tag_mem [0:NLINES-1];
   logic [NLINES-1:0]           valid_q;
   cache_pkg::cache_addr_u      hold_addr;
   cache_pkg::cache_addr_u      rd_addr;
   logic [cache_pkg::TAG_W-1:0] tag_q;
   logic                        line_valid_q;
   logic                        look_q;   // tag_q and store word belong to hold_addr
   logic                        hit;

   // read the new request at once or keep reading the held one
   assign rd_addr          = req_i.valid ? req_i.addr : hold_addr;
   assign store_rd_index_o = rd_addr.f.index;
   assign store_rd_word_o  = rd_addr.f.word_off;

   assign hit           = line_valid_q && (tag_q == hold_addr.f.tag);
   assign lookup_done_o = look_q && hit;
   assign dat_o         = store_rd_data_i;
   assign refill_addr_o = {hold_addr.f.tag, hold_addr.f.index};

   always_ff @(posedge clk_i) begin
      if (req_i.valid) begin
         hold_addr <= req_i.addr;
      end
      if (refill_done_i) begin
         tag_mem[hold_addr.f.index] <= hold_addr.f.tag;
         tag_q                      <= hold_addr.f.tag;   // bypass for the replay
      end else begin
         tag_q <= tag_mem[rd_addr.f.index];
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         valid_q      <= '0;
         line_valid_q <= 1'b0;
         look_q       <= 1'b0;
         refill_req_o <= 1'b0;
      end else begin
         look_q <= req_i.valid || refill_done_i;   // refill done replays the lookup
         if (refill_done_i) begin
            valid_q[hold_addr.f.index] <= 1'b1;
            line_valid_q               <= 1'b1;
         end else begin
            line_valid_q <= valid_q[rd_addr.f.index];
         end
         // a miss holds the request until the line is in
         if (refill_done_i) begin
            refill_req_o <= 1'b0;
         end else if (look_q && !hit) begin
            refill_req_o <= 1'b1;
         end
      end
   end

   a_refill_held : assert property (@(posedge clk_i) disable iff (reset)
      refill_done_i |-> refill_req_o)
      else $error("refill done without a pending refill request");

endmodule

//--- rtl/cache_line_store.sv
module cache_line_store (
   input  logic                                 clk_i,
   input  cache_pkg::line_fill_t                fill_i,
   input  logic [cache_pkg::INDEX_W-1:0]        rd_index_i,
   input  logic [cache_pkg::WORD_OFF_W-1:0]     rd_word_i,
   output logic [cache_pkg::DATA_W-1:0]         rd_data_o
);

   localparam int DEPTH = 1 << (cache_pkg::INDEX_W + cache_pkg::WORD_OFF_W);

   logic [cache_pkg::DATA_W-1:0] mem [0:DEPTH-1];

   // write port, one refill beat per cycle
   always_ff @(posedge clk_i) begin
      if (fill_i.we) begin
         mem[{fill_i.index, fill_i.word}] <= fill_i.data;
      end
   end

   // registered read, one cycle of latency
   always_ff @(posedge clk_i) begin
      rd_data_o <= mem[{rd_index_i, rd_word_i}];
   end

endmodule

//--- rtl/cache_refill_axi.sv
module cache_refill_axi #(
   parameter logic [cache_pkg::AXI_ID_W-1:0] AXI_ID = '0
) (
   input  logic                                            clk_i,
   input  logic                                            reset,
   input  logic                                            refill_req_i,
   input  logic [cache_pkg::TAG_W+cache_pkg::INDEX_W-1:0]  refill_addr_i,
   output logic                                            refill_done_o,
   output cache_pkg::line_fill_t                           fill_o,
   output cache_pkg::axi_ar_t                              axi_ar_o,
   output logic                                            axi_arvalid_o,
   input  logic                                            axi_arready_i,
   input  cache_pkg::axi_r_t                               axi_r_i,
   input  logic                                            axi_rvalid_i,
   output logic                                            axi_rready_o
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_LOAD = 2'd2;
   localparam logic [1:0] ST_END  = 2'd3;

   localparam int LINE_WORDS = 1 << cache_pkg::WORD_OFF_W;

   logic [1:0]                          state_q;
   logic                                slave_err_q;   // error kept until the burst ends
   logic [cache_pkg::WORD_OFF_W-1:0]    beat_q;
   logic                                beat_take;

   assign axi_arvalid_o = (state_q == ST_ADDR);
   assign axi_rready_o  = (state_q == ST_LOAD);   // no back-pressure on read data
   assign beat_take     = axi_rvalid_i && axi_rready_o;

   // fixed line-aligned burst shape
   assign axi_ar_o.id    = AXI_ID;
   assign axi_ar_o.addr  = {refill_addr_i, {(cache_pkg::WORD_OFF_W+cache_pkg::BYTE_OFF_W){1'b0}}};
   assign axi_ar_o.len   = 8'(LINE_WORDS - 1);
   assign axi_ar_o.size  = 3'(cache_pkg::BYTE_OFF_W);   // one word per beat
   assign axi_ar_o.burst = 2'b01;                        // incrementing
   assign axi_ar_o.cache = 4'b0011;
   assign axi_ar_o.prot  = 3'd0;

   assign fill_o.we    = beat_take;
   assign fill_o.index = refill_addr_i[cache_pkg::INDEX_W-1:0];
   assign fill_o.word  = beat_q;
   assign fill_o.data  = axi_r_i.data;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state_q       <= ST_IDLE;
         slave_err_q   <= 1'b0;
         beat_q        <= '0;
         refill_done_o <= 1'b0;
      end else begin
         // one cycle after end gives the store time for its read latency
         refill_done_o <= (state_q == ST_END) && !slave_err_q;
         case (state_q)
            ST_IDLE: begin
               slave_err_q <= 1'b0;
               beat_q      <= '0;
               // request is still high while done is out
               if (refill_req_i && !refill_done_o) begin
                  state_q <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               slave_err_q <= 1'b0;
               beat_q      <= '0;
               if (axi_arready_i) begin
                  state_q <= ST_LOAD;
               end
            end
            ST_LOAD: begin
               if (beat_take) begin
                  if (axi_r_i.resp != 2'b00) begin
                     slave_err_q <= 1'b1;
                  end
                  if (axi_r_i.last) begin
                     state_q <= ST_END;   // count stays on the last word
                  end else begin
                     beat_q <= beat_q + 1'b1;
                  end
               end
            end
            default: begin
               // an error anywhere in the burst means the whole line again
               if (slave_err_q) begin
                  state_q <= ST_ADDR;
               end else begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   a_arvalid_held : assert property (@(posedge clk_i) disable iff (reset)
      axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_ar_o))
      else $error("arvalid dropped or address fields changed before arready");

endmodule

//--- rtl/cache_top.sv
module cache_top #(
   parameter logic [cache_pkg::AXI_ID_W-1:0] AXI_ID = 4'h1
) (
   input  logic                            clk_i,
   input  logic                            reset,
   // wishbone classic slave
   input  logic                            wb_cyc_i,
   input  logic                            wb_stb_i,
   input  logic                            wb_we_i,
   input  logic [cache_pkg::ADDR_W-1:0]    wb_adr_i,
   output logic                            wb_ack_o,
   output logic                            wb_err_o,
   output logic [cache_pkg::DATA_W-1:0]    wb_dat_o,
   // axi4 read master
   output cache_pkg::axi_ar_t              axi_ar_o,
   output logic                            axi_arvalid_o,
   input  logic                            axi_arready_i,
   input  cache_pkg::axi_r_t               axi_r_i,
   input  logic                            axi_rvalid_i,
   output logic                            axi_rready_o
);

   cache_pkg::cache_req_t                          req;
   logic                                           lookup_done;
   logic [cache_pkg::DATA_W-1:0]                   lookup_data;
   logic                                           refill_req;
   logic                                           refill_done;
   logic [cache_pkg::TAG_W+cache_pkg::INDEX_W-1:0] refill_addr;
   cache_pkg::line_fill_t                          fill;
   logic [cache_pkg::INDEX_W-1:0]                  rd_index;
   logic [cache_pkg::WORD_OFF_W-1:0]               rd_word;
   logic [cache_pkg::DATA_W-1:0]                   rd_data;

   cache_req_stage req_stage0 (
      .clk_i         (clk_i),
      .reset         (reset),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_ack_o      (wb_ack_o),
      .wb_err_o      (wb_err_o),
      .wb_dat_o      (wb_dat_o),
      .req_o         (req),
      .lookup_done_i (lookup_done),
      .lookup_data_i (lookup_data)
   );

   cache_tag_stage tag_stage0 (
      .clk_i            (clk_i),
      .reset            (reset),
      .req_i            (req),
      .lookup_done_o    (lookup_done),
      .dat_o            (lookup_data),
      .refill_req_o     (refill_req),
      .refill_addr_o    (refill_addr),
      .refill_done_i    (refill_done),
      .store_rd_index_o (rd_index),
      .store_rd_word_o  (rd_word),
      .store_rd_data_i  (rd_data)
   );

   cache_line_store line_store0 (
      .clk_i      (clk_i),
      .fill_i     (fill),
      .rd_index_i (rd_index),
      .rd_word_i  (rd_word),
      .rd_data_o  (rd_data)
   );

   cache_refill_axi #(
      .AXI_ID (AXI_ID)
   ) refill0 (
      .clk_i         (clk_i),
      .reset         (reset),
      .refill_req_i  (refill_req),
      .refill_addr_i (refill_addr),
      .refill_done_o (refill_done),
      .fill_o        (fill),
      .axi_ar_o      (axi_ar_o),
      .axi_arvalid_o (axi_arvalid_o),
      .axi_arready_i (axi_arready_i),
      .axi_r_i       (axi_r_i),
      .axi_rvalid_i  (axi_rvalid_i),
      .axi_rready_o  (axi_rready_o)
   );

endmodule

//--- tests/axi_mem_model.sv
module axi_mem_model (
   input  logic               clk_i,
   input  logic               reset,
   input  cache_pkg::axi_ar_t ar_i,
   input  logic               arvalid_i,
   output logic               arready_o,
   output cache_pkg::axi_r_t  r_o,
   output logic               rvalid_o,
   input  logic               rready_i
);

   integer      seed = 32'hb079;
   logic        busy_q = 1'b0;       // burst being returned
   logic [31:0] addr_q = '0;
   logic [7:0]  len_q = '0;
   logic [7:0]  beat_q = '0;
   logic        err_on_q = 1'b0;
   logic [7:0]  err_beat_q = '0;
   logic        last_err_q = 1'b0;   // previous burst carried an error
   logic        pick_err;

   // data depends on every word address bit
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      return ({2'b00, addr[31:2]} * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
   endfunction

   always_comb begin
      r_o.data = mem_word(addr_q + (32'(beat_q) << 2));
      r_o.resp = (err_on_q && beat_q == err_beat_q) ? 2'b10 : 2'b00;   // SLVERR on one beat
      r_o.last = (beat_q == len_q);
   end

   initial begin
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
   end

   always @(posedge clk_i or posedge reset) begin
      if (reset) begin
         arready_o  <= 1'b0;
         rvalid_o   <= 1'b0;
         busy_q     <= 1'b0;
         beat_q     <= '0;
         err_on_q   <= 1'b0;
         last_err_q <= 1'b0;
      end else if (!busy_q) begin
         if (arvalid_i && arready_o) begin
            arready_o <= 1'b0;
            busy_q    <= 1'b1;
            addr_q    <= ar_i.addr;
            len_q     <= ar_i.len;
            beat_q    <= '0;
            // about one burst in four, never two in a row
            pick_err   = !last_err_q && (($random(seed) & 3) == 0);
            err_on_q   <= pick_err;
            last_err_q <= pick_err;
            err_beat_q <= 8'($random(seed) & 3);
         end else if (arvalid_i) begin
            arready_o <= (($random(seed) & 1) == 1);   // random address delay
         end
      end else if (rvalid_o && rready_i) begin
         if (r_o.last) begin
            rvalid_o <= 1'b0;
            busy_q   <= 1'b0;
         end else begin
            beat_q   <= beat_q + 8'd1;
            rvalid_o <= (($random(seed) & 1) == 1);
         end
      end else if (!rvalid_o) begin
         rvalid_o <= (($random(seed) % 3) != 0);
      end
   end

endmodule

//--- tests/tb_cache.sv
module tb_cache;

   localparam logic [cache_pkg::AXI_ID_W-1:0] TB_AXI_ID = 4'h5;
   localparam int WB_TIMEOUT = 300;   // cycles per bus cycle

   logic               clk_i;
   logic               reset;
   logic               wb_cyc;
   logic               wb_stb;
   logic               wb_we;
   logic [31:0]        wb_adr;
   logic               wb_ack;
   logic               wb_err;
   logic [31:0]        wb_dat;
   cache_pkg::axi_ar_t axi_ar;
   logic               axi_arvalid;
   logic               axi_arready;
   cache_pkg::axi_r_t  axi_r;
   logic               axi_rvalid;
   logic               axi_rready;

   integer      seed = 32'hb079;
   int          errors = 0;
   int          checks = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          ar_count = 0;
   int          retry_count = 0;
   logic        timed_out = 1'b0;
   logic        retry_due = 1'b0;   // an error beat was seen and the line is due again
   logic [31:0] retry_addr;
   logic [31:0] last_ar_addr;
   logic [31:0] cur_line;
   logic [23:0] model_tag [0:15];   // tag held per index
   logic [15:0] model_valid;

   cache_top #(.AXI_ID(TB_AXI_ID)) dut0 (
      .clk_i         (clk_i),
      .reset         (reset),
      .wb_cyc_i      (wb_cyc),
      .wb_stb_i      (wb_stb),
      .wb_we_i       (wb_we),
      .wb_adr_i      (wb_adr),
      .wb_ack_o      (wb_ack),
      .wb_err_o      (wb_err),
      .wb_dat_o      (wb_dat),
      .axi_ar_o      (axi_ar),
      .axi_arvalid_o (axi_arvalid),
      .axi_arready_i (axi_arready),
      .axi_r_i       (axi_r),
      .axi_rvalid_i  (axi_rvalid),
      .axi_rready_o  (axi_rready)
   );

   axi_mem_model mem0 (
      .clk_i     (clk_i),
      .reset     (reset),
      .ar_i      (axi_ar),
      .arvalid_i (axi_arvalid),
      .arready_o (axi_arready),
      .r_o       (axi_r),
      .rvalid_o  (axi_rvalid),
      .rready_i  (axi_rready)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      return ({2'b00, addr[31:2]} * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
   endfunction

   function automatic logic predict_hit(input logic [31:0] addr);
      return model_valid[addr[7:4]] && (model_tag[addr[7:4]] == addr[31:8]);
   endfunction

   // AR fields are stable at the falling edge before the handshake edge
   always @(negedge clk_i) begin
      if (!reset && axi_arvalid && axi_arready) begin
         ar_count++;
         checks++;
         if (axi_ar.addr != cur_line || axi_ar.len != 8'd3 || axi_ar.size != 3'd2 ||
             axi_ar.burst != 2'b01 || axi_ar.id != TB_AXI_ID) begin
            $display("Mismatch at %0t: AR addr %h len %0d size %0d burst %b id %h, line %h",
                     $time, axi_ar.addr, axi_ar.len, axi_ar.size, axi_ar.burst, axi_ar.id,
                     cur_line);
            errors++;
         end
         if (axi_ar.cache != 4'b0011 || axi_ar.prot != 3'd0) begin
            $display("Mismatch at %0t: AR cache %b prot %0d, expected 0011 and 0",
                     $time, axi_ar.cache, axi_ar.prot);
            errors++;
         end
         if (retry_due) begin
            retry_count++;
            retry_due = 1'b0;
            if (axi_ar.addr != retry_addr) begin
               $display("Mismatch at %0t: retry AR addr %h, expected %h",
                        $time, axi_ar.addr, retry_addr);
               errors++;
            end
         end
         last_ar_addr = axi_ar.addr;
      end
      // read data is only offered during a burst, where rready must be high
      if (!reset && axi_rvalid && !axi_rready) begin
         $display("Mismatch at %0t: read data offered while rready is low", $time);
         errors++;
      end
      if (!reset && axi_rvalid && axi_rready && axi_r.resp != 2'b00) begin
         retry_due  = 1'b1;
         retry_addr = last_ar_addr;
      end
   end

   // one classic cycle
   // cycles counts rising edges from the drive edge to the answer
   task automatic wb_cycle(input logic we, input logic [31:0] addr, output logic got_ack,
                           output logic got_err, output logic [31:0] got_dat, output int cycles);
      got_ack = 1'b0;
      got_err = 1'b0;
      got_dat = '0;
      cycles  = 0;
      @(posedge clk_i);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= we;
      wb_adr <= addr;
      while (!got_ack && !got_err && cycles < WB_TIMEOUT) begin
         @(posedge clk_i);
         cycles++;
         @(negedge clk_i);
         got_ack = wb_ack;
         got_err = wb_err;
         got_dat = wb_dat;
      end
      @(posedge clk_i);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge clk_i);
      if (!got_ack && !got_err) begin
         $display("timeout: no ack or err for address %h within %0d cycles", addr, WB_TIMEOUT);
         timed_out = 1'b1;
         errors++;
      end else if (wb_ack || wb_err) begin
         $display("answer for address %h was held longer than one cycle", addr);
         errors++;
      end
   endtask

   task automatic check_read(input logic [31:0] addr);
      logic        exp_hit;
      logic        got_ack;
      logic        got_err;
      logic [31:0] got_dat;
      int          cycles;
      int          ar_before;
      exp_hit   = predict_hit(addr);
      ar_before = ar_count;
      cur_line  = {addr[31:4], 4'h0};
      if (!timed_out) begin
         wb_cycle(1'b0, addr, got_ack, got_err, got_dat, cycles);
      end
      if (!timed_out) begin
         checks++;
         if (!got_ack || got_err || got_dat !== mem_word(addr)) begin
            $display("Mismatch at %0t: read %h gave ack %b err %b data %h, expected %h",
                     $time, addr, got_ack, got_err, got_dat, mem_word(addr));
            errors++;
         end
         if (exp_hit ? (cycles != 3 || ar_count != ar_before) : (ar_count == ar_before)) begin
            $display("Mismatch at %0t: read %h predicted hit %b, %0d cycles, %0d bursts",
                     $time, addr, exp_hit, cycles, ar_count - ar_before);
            errors++;
         end
         model_valid[addr[7:4]] = 1'b1;
         model_tag[addr[7:4]]   = addr[31:8];
      end
   endtask

   task automatic check_write(input logic [31:0] addr);
      logic        got_ack;
      logic        got_err;
      logic [31:0] got_dat;
      int          cycles;
      int          ar_before;
      ar_before = ar_count;
      if (!timed_out) begin
         wb_cycle(1'b1, addr, got_ack, got_err, got_dat, cycles);
      end
      if (!timed_out) begin
         checks++;
         if (got_ack || !got_err || cycles != 1 || ar_count != ar_before) begin
            $display("Mismatch at %0t: write %h gave ack %b err %b after %0d cycles, %0d bursts",
                     $time, addr, got_ack, got_err, cycles, ar_count - ar_before);
            errors++;
         end
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      tests_run++;
      if (errors == err_start && !timed_out) begin
         $display("test %0d %s: pass", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - err_start);
      end
   endtask

   initial begin
      int          err_start;
      int          ar_start;
      int          retry_start;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [23:0] tag_pool [0:3];
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      reset       = 1'b1;
      model_valid = '0;
      repeat (10) @(posedge clk_i);
      reset <= 1'b0;

      err_start = errors;
      a = $random(seed);
      check_read(a);
      for (int i = 0; i < 4; i++) begin
         check_read({a[31:4], 2'(i), 2'b00});   // every word of the line now hits
      end
      finish_test("miss then hit", err_start);

      err_start = errors;
      ar_start  = ar_count;
      for (int i = 0; i < 8; i++) begin
         check_read($random(seed));
      end
      if (!timed_out && ar_count == ar_start) begin
         $display("no AXI burst was seen for eight reads of new lines");
         errors++;
      end
      finish_test("burst form", err_start);

      err_start = errors;
      a = $random(seed);
      b = {a[31:8] ^ 24'h00_0100, a[7:0]};   // same index with another tag
      for (int i = 0; i < 6; i++) begin
         r        = (i % 2 == 0) ? a : b;
         ar_start = ar_count;
         check_read(r);
         if (!timed_out && ar_count == ar_start) begin
            $display("Mismatch at %0t: alternation %0d read %h caused no refill", $time, i, r);
            errors++;
         end
      end
      finish_test("conflict eviction", err_start);

      err_start   = errors;
      retry_start = retry_count;
      for (int i = 0; i < 40 && retry_count == retry_start; i++) begin
         check_read($random(seed));
      end
      if (!timed_out && retry_count == retry_start) begin
         $display("no error response was seen in 40 refills");
         errors++;
      end
      finish_test("error retry", err_start);

      err_start = errors;
      for (int i = 0; i < 4; i++) begin
         check_write($random(seed));
      end
      check_write(b);   // a refused write must leave the line of b alone
      check_read(b);
      finish_test("write refusal", err_start);

      err_start = errors;
      for (int i = 0; i < 4; i++) begin
         tag_pool[i] = 24'($random(seed));
      end
      for (int i = 0; i < 300; i++) begin
         r = $random(seed);
         a = {tag_pool[r[1:0]], 2'b00, r[3:2], r[5:4], r[7:6]};   // 4 tags on 4 indexes
         if (r[9:8] == 2'b00) begin
            check_write(a);
         end else begin
            check_read(a);
         end
      end
      finish_test("random mix", err_start);

      $display("tests %0d, failed %0d, checks %0d, errors %0d, retries %0d",
               tests_run, tests_failed, checks, errors, retry_count);
      if (errors == 0 && !timed_out) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- cache.f
rtl/cache_pkg.sv
rtl/cache_req_stage.sv
rtl/cache_tag_stage.sv
rtl/cache_line_store.sv
rtl/cache_refill_axi.sv
rtl/cache_top.sv
tests/axi_mem_model.sv
tests/tb_cache.sv
